// File: hw/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

    // datapath and address widths
    localparam int XLEN   = 64;
    localparam int ADDR_W = 32;

    // byte lanes per data word
    localparam int STRB_W = XLEN / 8;
    localparam int OFS_W  = $clog2(STRB_W);

    // data memory geometry, word index taken from addr[10:3]
    localparam int SRAM_DEPTH = 256;
    localparam int SRAM_IDX_W = $clog2(SRAM_DEPTH);
    localparam int MEM_BYTES  = SRAM_DEPTH * STRB_W;

    // memory opcodes, bit 3 set for stores
    typedef enum logic [3:0] {
        OP_LB   = 4'b0000,
        OP_LBU  = 4'b0001,
        OP_LH   = 4'b0010,
        OP_LHU  = 4'b0011,
        OP_LW   = 4'b0100,
        OP_LWU  = 4'b0101,
        OP_LD   = 4'b0110,
        OP_SB   = 4'b1000,
        OP_SH   = 4'b1001,
        OP_SW   = 4'b1010,
        OP_SD   = 4'b1011,
        OP_NONE = 4'b1111
    } mem_op_e;

    // access size, log2 of the byte count
    typedef enum logic [1:0] {
        SZ_B = 2'd0,
        SZ_H = 2'd1,
        SZ_W = 2'd2,
        SZ_D = 2'd3
    } acc_size_e;

    typedef struct packed {
        mem_op_e           op;
        logic [ADDR_W-1:0] addr;
        logic [XLEN-1:0]   wdata;
    } mem_req_t;

    typedef struct packed {
        logic [XLEN-1:0] rdata;
        // misaligned address or unknown opcode
        logic            err;
    } mem_resp_t;

    // wdata and wmask sit in the low lanes, the SRAM moves them
    typedef struct packed {
        logic              rd_en;
        logic              wr_en;
        logic [ADDR_W-1:0] addr;
        logic [XLEN-1:0]   wdata;
        logic [STRB_W-1:0] wmask;
        acc_size_e         size;
    } sram_req_t;

endpackage

`default_nettype wire

// File: hw/lsu.sv
`timescale 1ns/1ps
`default_nettype none

module lsu
    import lsu_pkg::*;
(
    input  wire logic            go,
    input  wire mem_req_t        cur_req,
    output sram_req_t            sram_req,
    input  wire logic [XLEN-1:0] sram_rd_data,
    input  wire logic            sram_not_ok,
    output logic      [XLEN-1:0] ls_res,
    output logic                 ls_not_ok,
    output logic                 misaligned
);

    logic            is_load;
    logic            is_store;
    logic            is_unsigned;
    acc_size_e       size;
    logic            bad_addr;
    logic            load_ok;
    logic [XLEN-1:0] rd_shift;
    logic [7:0]      rd_b;
    logic [15:0]     rd_h;
    logic [31:0]     rd_w;

    // opcode decode
    always_comb begin
        is_load     = 1'b0;
        is_store    = 1'b0;
        is_unsigned = 1'b0;
        size        = SZ_B;
        case (cur_req.op)
            OP_LB: begin
                is_load = 1'b1;
            end
            OP_LBU: begin
                is_load     = 1'b1;
                is_unsigned = 1'b1;
            end
            OP_LH: begin
                is_load = 1'b1;
                size    = SZ_H;
            end
            OP_LHU: begin
                is_load     = 1'b1;
                is_unsigned = 1'b1;
                size        = SZ_H;
            end
            OP_LW: begin
                is_load = 1'b1;
                size    = SZ_W;
            end
            OP_LWU: begin
                is_load     = 1'b1;
                is_unsigned = 1'b1;
                size        = SZ_W;
            end
            OP_LD: begin
                is_load = 1'b1;
                size    = SZ_D;
            end
            OP_SB: begin
                is_store = 1'b1;
            end
            OP_SH: begin
                is_store = 1'b1;
                size     = SZ_H;
            end
            OP_SW: begin
                is_store = 1'b1;
                size     = SZ_W;
            end
            OP_SD: begin
                is_store = 1'b1;
                size     = SZ_D;
            end
            default: begin
                size = SZ_B;
            end
        endcase
    end

    // natural alignment only
    always_comb begin
        case (size)
            SZ_H:    bad_addr = cur_req.addr[0];
            SZ_W:    bad_addr = |cur_req.addr[1:0];
            SZ_D:    bad_addr = |cur_req.addr[OFS_W-1:0];
            default: bad_addr = 1'b0;
        endcase
    end

    assign misaligned = bad_addr || !(is_load || is_store);

    // sram command, enables only for a legal access
    always_comb begin
        sram_req.rd_en = go && is_load && !misaligned;
        sram_req.wr_en = go && is_store && !misaligned;
        sram_req.addr  = cur_req.addr;
        sram_req.wdata = cur_req.wdata;
        sram_req.size  = size;
        case (size)
            SZ_B:    sram_req.wmask = 8'h01;
            SZ_H:    sram_req.wmask = 8'h03;
            SZ_W:    sram_req.wmask = 8'h0f;
            default: sram_req.wmask = 8'hff;
        endcase
        if (!is_store) begin
            sram_req.wmask = '0;
        end
    end

    assign ls_not_ok = sram_not_ok;

    // bring the addressed lane down to bit 0
    assign rd_shift = sram_rd_data >> {cur_req.addr[OFS_W-1:0], 3'b000};
    assign rd_b     = rd_shift[7:0];
    assign rd_h     = rd_shift[15:0];
    assign rd_w     = rd_shift[31:0];
    assign load_ok  = is_load && !misaligned;

    // sign or zero extension, zero for stores and refused requests
    always_comb begin
        ls_res = '0;
        if (load_ok) begin
            case (size)
                SZ_B:    ls_res = {{56{rd_b[7] && !is_unsigned}}, rd_b};
                SZ_H:    ls_res = {{48{rd_h[15] && !is_unsigned}}, rd_h};
                SZ_W:    ls_res = {{32{rd_w[31] && !is_unsigned}}, rd_w};
                default: ls_res = sram_rd_data;
            endcase
        end
    end

    // an enabled access never spills past its word
    always_comb begin
        a_in_word: assert final (
            !(sram_req.rd_en || sram_req.wr_en)
            || ((int'(cur_req.addr[OFS_W-1:0]) + (1 << sram_req.size)) <= STRB_W)
        );
    end

endmodule

`default_nettype wire

// File: hw/data_sram.sv
`timescale 1ns/1ps
`default_nettype none

module data_sram
    import lsu_pkg::*;
(
    input  wire logic            clk,
    input  wire logic            rst_n,
    input  wire sram_req_t       sram_req,
    output logic      [XLEN-1:0] rd_data,
    output logic                 data_not_ok
);

    logic [XLEN-1:0]       mem [SRAM_DEPTH];
    logic [SRAM_IDX_W-1:0] idx;
    logic [OFS_W-1:0]      ofs;
    logic [XLEN-1:0]       lane_data;
    logic [STRB_W-1:0]     lane_mask;
    logic                  rd_pend;
    logic                  rd_first;
    logic [XLEN-1:0]       rd_q;

    // word index from addr[10:3], higher bits ignored
    assign idx = sram_req.addr[OFS_W +: SRAM_IDX_W];
    assign ofs = sram_req.addr[OFS_W-1:0];

    // move low-lane data and mask to the addressed lanes
    assign lane_data = sram_req.wdata << {ofs, 3'b000};
    assign lane_mask = sram_req.wmask << ofs;

    // byte-masked write at the edge
    always_ff @(posedge clk) begin
        if (sram_req.wr_en) begin
            for (int b = 0; b < STRB_W; b++) begin
                if (lane_mask[b]) begin
                    mem[idx][b*8 +: 8] <= lane_data[b*8 +: 8];
                end
            end
        end
    end

    // first cycle of a read, data not there yet
    assign rd_first = sram_req.rd_en && !rd_pend;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_pend <= 1'b0;
        end else begin
            rd_pend <= rd_first;
        end
    end

    // read word captured at the end of the wait cycle
    always_ff @(posedge clk) begin
        if (rd_first) begin
            rd_q <= mem[idx];
        end
    end

    assign rd_data     = rd_q;
    assign data_not_ok = rd_first;

    // writes must land inside the modelled range
    a_wr_in_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        sram_req.wr_en |-> (sram_req.addr < MEM_BYTES)
    );

    // a read started must be held for its data cycle
    a_rd_held: assert property (
        @(posedge clk) disable iff (!rst_n)
        rd_first |=> sram_req.rd_en
    );

endmodule

`default_nettype wire

// File: hw/mem_stage.sv
`timescale 1ns/1ps
`default_nettype none

module mem_stage
    import lsu_pkg::*;
(
    input  wire logic            clk,
    input  wire logic            rst_n,
    input  wire mem_req_t        req,
    input  wire logic            req_valid,
    output logic                 req_ready,
    output mem_resp_t            resp,
    output logic                 resp_valid,
    input  wire logic            resp_ready,
    output mem_req_t             cur_req,
    output logic                 go,
    input  wire logic [XLEN-1:0] ls_res,
    input  wire logic            ls_not_ok,
    input  wire logic            misaligned
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ACCESS,
        ST_RESP
    } state_e;

    state_e    state_q;
    mem_req_t  req_q;
    mem_resp_t resp_q;
    logic      accept;
    logic      done;

    assign accept = req_valid && req_ready;
    // refused requests finish without waiting on the SRAM
    assign done   = (state_q == ST_ACCESS) && (misaligned || !ls_not_ok);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= ST_IDLE;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (accept) begin
                        state_q <= ST_ACCESS;
                    end
                end
                ST_ACCESS: begin
                    if (done) begin
                        state_q <= ST_RESP;
                    end
                end
                ST_RESP: begin
                    if (resp_ready) begin
                        state_q <= ST_IDLE;
                    end
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    // request held for the whole access
    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= req;
        end
    end

    // result and error frozen until the response is taken
    always_ff @(posedge clk) begin
        if (done) begin
            resp_q.rdata <= ls_res;
            resp_q.err   <= misaligned;
        end
    end

    assign req_ready  = (state_q == ST_IDLE);
    assign resp_valid = (state_q == ST_RESP);
    assign go         = (state_q == ST_ACCESS);
    assign cur_req    = req_q;
    assign resp       = resp_q;

    a_resp_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        (resp_valid && !resp_ready) |=> (resp_valid && $stable(resp))
    );

endmodule

`default_nettype wire

// File: hw/mem_subsys.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsys
    import lsu_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      rst_n,
    input  wire mem_req_t  req,
    input  wire logic      req_valid,
    output logic           req_ready,
    output mem_resp_t      resp,
    output logic           resp_valid,
    input  wire logic      resp_ready
);

    mem_req_t        cur_req;
    logic            go;
    sram_req_t       sram_req;
    logic [XLEN-1:0] rd_data;
    logic            data_not_ok;
    logic [XLEN-1:0] ls_res;
    logic            ls_not_ok;
    logic            misaligned;

    // handshake and response holding
    mem_stage u_mem_stage (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (req),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .resp       (resp),
        .resp_valid (resp_valid),
        .resp_ready (resp_ready),
        .cur_req    (cur_req),
        .go         (go),
        .ls_res     (ls_res),
        .ls_not_ok  (ls_not_ok),
        .misaligned (misaligned)
    );

    lsu u_lsu (
        .go           (go),
        .cur_req      (cur_req),
        .sram_req     (sram_req),
        .sram_rd_data (rd_data),
        .sram_not_ok  (data_not_ok),
        .ls_res       (ls_res),
        .ls_not_ok    (ls_not_ok),
        .misaligned   (misaligned)
    );

    data_sram u_data_sram (
        .clk         (clk),
        .rst_n       (rst_n),
        .sram_req    (sram_req),
        .rd_data     (rd_data),
        .data_not_ok (data_not_ok)
    );

endmodule

`default_nettype wire

// File: test/tb_mem_subsys.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_subsys
    import lsu_pkg::*;
();

    typedef struct packed {
        mem_op_e           op;
        logic [ADDR_W-1:0] addr;
        logic [XLEN-1:0]   wdata;
        logic [7:0]        stall;
    } row_t;

    logic      clk;
    logic      rst_n;
    mem_req_t  req;
    logic      req_valid;
    logic      req_ready;
    mem_resp_t resp;
    logic      resp_valid;
    logic      resp_ready;

    // byte image of the data memory
    logic [7:0]  ref_mem [MEM_BYTES];
    row_t        rows [$];

    mem_subsys uut (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (req),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .resp       (resp),
        .resp_valid (resp_valid),
        .resp_ready (resp_ready)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // inputs change 2 ns after the edge
    task automatic step();
        @(posedge clk);
        #2;
    endtask

    task automatic stop_run();
        $display("test failed");
        $fatal(1);
    endtask

    task automatic timeout_on(input string sig);
        $display("timeout: %s never arrived within 50 cycles", sig);
        stop_run();
    endtask

    task automatic check_bit(input string name, input logic act, input logic exp);
        if (act !== exp) begin
            $display("ERR %0t %s expected %b actual %b", $time, name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_resp(input string name, input mem_resp_t act, input mem_resp_t exp);
        if (act !== exp) begin
            $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_int(input string name, input int act, input int exp);
        if (act != exp) begin
            $display("ERR %0t %s expected %0d actual %0d", $time, name, exp, act);
            stop_run();
        end
    endtask

    function automatic int op_bytes(input mem_op_e op);
        case (op)
            OP_LB, OP_LBU, OP_SB: return 1;
            OP_LH, OP_LHU, OP_SH: return 2;
            OP_LW, OP_LWU, OP_SW: return 4;
            OP_LD, OP_SD:         return 8;
            default:              return 0;
        endcase
    endfunction

    // expected response, and the store's effect on the byte image
    task automatic apply_model(input row_t r, output mem_resp_t e);
        int              nb;
        logic [XLEN-1:0] v;
        nb = op_bytes(r.op);
        e  = '0;
        v  = '0;
        if (nb == 0 || (r.addr % nb) != 0) begin
            e.err = 1'b1;
        end else if (r.op[3]) begin
            for (int b = 0; b < nb; b++) begin
                ref_mem[r.addr + b] = r.wdata[b*8 +: 8];
            end
        end else begin
            for (int b = nb - 1; b >= 0; b--) begin
                v = {v[XLEN-9:0], ref_mem[r.addr + b]};
            end
            // signed loads copy the top loaded bit upward
            if ((r.op inside {OP_LB, OP_LH, OP_LW}) && v[nb*8-1]) begin
                v = v | (~64'h0 << (nb * 8));
            end
            e.rdata = v;
        end
    endtask

    task automatic add_row(input mem_op_e op, input int addr, input logic [XLEN-1:0] wdata);
        row_t r;
        r.op    = op;
        r.addr  = addr;
        r.wdata = wdata;
        r.stall = '0;
        rows.push_back(r);
    endtask

    task automatic build_table();
        mem_op_e st_ops [4] = '{OP_SB, OP_SH, OP_SW, OP_SD};
        mem_op_e ld_ops [7] = '{OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW, OP_LWU, OP_LD};
        int      half;
        row_t    r;
        // random background in words 0 to 15
        for (int w = 0; w < 16; w++) begin
            add_row(OP_SD, w * 8, {$urandom, $urandom});
        end
        // every size at every legal lane of word 8, each read back whole
        foreach (st_ops[i]) begin
            for (int a = 0; a < 8; a += op_bytes(st_ops[i])) begin
                add_row(st_ops[i], 'h40 + a, {$urandom, $urandom});
                add_row(OP_LD, 'h40, '0);
            end
        end
        // negative bytes, halves and words in word 9
        add_row(OP_SD, 'h48, 64'h8000_7fff_ff80_817f);
        foreach (ld_ops[i]) begin
            for (int a = 0; a < 8; a += op_bytes(ld_ops[i])) begin
                add_row(ld_ops[i], 'h48 + a, '0);
            end
        end
        // refused requests, then the words they would touch
        add_row(OP_LH, 'h49, '0);
        add_row(OP_LW, 'h4a, '0);
        add_row(OP_LD, 'h44, '0);
        add_row(OP_SH, 'h43, {$urandom, $urandom});
        add_row(OP_SD, 'h41, {$urandom, $urandom});
        add_row(OP_NONE, 'h40, {$urandom, $urandom});
        add_row(OP_LD, 'h40, '0);
        add_row(OP_LD, 'h48, '0);
        // second half replays the first under resp_ready stalls
        half = rows.size();
        for (int i = 0; i < half; i++) begin
            r       = rows[i];
            r.stall = $urandom % 6;
            rows.push_back(r);
        end
    endtask

    task automatic run_row(input row_t r);
        mem_resp_t exp;
        int        n;
        int        lat_exp;
        apply_model(r, exp);
        lat_exp = (!r.op[3] && !exp.err) ? 2 : 1;
        n = 0;
        while (!req_ready) begin
            step();
            n++;
            if (n > 50) timeout_on("req_ready");
        end
        req.op     = r.op;
        req.addr   = r.addr;
        req.wdata  = r.wdata;
        req_valid  = 1'b1;
        resp_ready = (r.stall == 0);
        step();
        req_valid = 1'b0;
        // n counts cycles after the accepting edge
        n = 0;
        while (!resp_valid) begin
            step();
            n++;
            if (n > 50) timeout_on("resp_valid");
        end
        if (r.stall == 0) begin
            check_int("latency", n, lat_exp);
        end
        for (int s = 0; s < r.stall; s++) begin
            check_resp("resp", resp, exp);
            check_bit("req_ready", req_ready, 1'b0);
            check_bit("resp_valid", resp_valid, 1'b1);
            step();
        end
        resp_ready = 1'b1;
        check_resp("resp", resp, exp);
        check_bit("req_ready", req_ready, 1'b0);
        step();
        // exactly one response per request
        check_bit("resp_valid", resp_valid, 1'b0);
        check_bit("req_ready", req_ready, 1'b1);
    endtask

    initial begin
        rst_n      = 1'b0;
        req        = '0;
        req_valid  = 1'b0;
        resp_ready = 1'b0;
        void'($urandom(19));
        build_table();
        repeat (8) @(posedge clk);
        #2;
        rst_n = 1'b1;
        check_bit("req_ready", req_ready, 1'b1);
        check_bit("resp_valid", resp_valid, 1'b0);
        foreach (rows[i]) begin
            run_row(rows[i]);
        end
        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: mem_subsys.f
hw/lsu_pkg.sv
hw/lsu.sv
hw/data_sram.sv
hw/mem_stage.sv
hw/mem_subsys.sv
test/tb_mem_subsys.sv

// File: Bender.yml
package:
  name: mem_subsys

sources:
  - hw/lsu_pkg.sv
  - hw/lsu.sv
  - hw/data_sram.sv
  - hw/mem_stage.sv
  - hw/mem_subsys.sv
  - target: test
    files:
      - test/tb_mem_subsys.sv
